//--- sim.f
verilog/mpu_pkg.sv
verilog/i2c_master.sv
verilog/sensor_timebase.sv
verilog/mpu_sequencer.sv
verilog/rx_fifo.sv
verilog/mpu9150_driver.sv
test/sensor_model.sv
test/tb_mpu9150_driver.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mpu9150_driver
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
LOG        := sim.log
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_mpu9150_driver.sv
// testbench for the mpu9150 driver with start-up, sampling and wrong id tests
`timescale 1ns/10ps
module tb_mpu9150_driver
	import mpu_pkg::*;
();

	localparam int SAMPLES = 10;
	// init fits in one sample period, then ten samples and the id test
	localparam int MAX_CYCLES = 3 * int'(SAMPLE_CYCLES) * (SAMPLES + 3);

	logic       CLK;
	logic       RSTn;
	logic       en;
	logic       fifo_rd;
	logic       scl;
	logic       sda_oe;
	logic       sda_line;
	logic       sda_low;
	logic       dat_rdy;
	logic       time_mark;
	drv_state_t state;
	logic [7:0] fifo_data;
	logic [5:0] fifo_count;
	logic [7:0] mpu_id;
	logic [7:0] ak_id;
	int         errors = 0;
	int         checks = 0;
	int         cycles = 0;
	int         marks = 0;

	assign sda_line = !sda_oe && !sda_low; // wired and with pull-up

	mpu9150_driver i_mpu9150_driver (
		.CLK        (CLK),
		.RSTn       (RSTn),
		.en         (en),
		.scl        (scl),
		.sda_oe     (sda_oe),
		.sda_in     (sda_line),
		.dat_rdy    (dat_rdy),
		.time_mark  (time_mark),
		.state      (state),
		.fifo_rd    (fifo_rd),
		.fifo_data  (fifo_data),
		.fifo_count (fifo_count)
	);

	sensor_model i_sensor_model (
		.CLK     (CLK),
		.RSTn    (RSTn),
		.scl     (scl),
		.sda     (sda_line),
		.sda_low (sda_low),
		.mpu_id  (mpu_id),
		.ak_id   (ak_id)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout after %0d cycles, the driver stopped making progress", cycles);
			$display("errors: %0d of %0d checks", errors, checks);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	always @(negedge CLK) begin
		if (time_mark)
			marks <= marks + 1;
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic apply_reset();
		@(negedge CLK);
		RSTn = 1'b0;
		repeat (8) @(negedge CLK);
		RSTn = 1'b1;
	endtask

	task automatic wait_for_state(input drv_state_t s);
		while (state != s)
			@(negedge CLK);
	endtask

	task automatic verify_reset_values();
		compare("state", 32'(state), 32'(CHK));
		compare("dat_rdy", 32'(dat_rdy), 32'd0);
		compare("time_mark", 32'(time_mark), 32'd0);
		compare("fifo_count", 32'(fifo_count), 32'd0);
		compare("scl", 32'(scl), 32'd1);
		compare("sda_oe", 32'(sda_oe), 32'd0);
	endtask

	task automatic startup_sequence();
		logic [22:0] expw [8];
		expw[0] = {MPU_ADDR, RA_PWR_MGMT_1, 8'h00}; // wake from sleep
		expw[1] = {MPU_ADDR, RA_INT_PIN_CFG, CFG_BYPASS};
		expw[2] = {MPU_ADDR, RA_USER_CTRL, 8'h00};
		expw[3] = {MPU_ADDR, RA_SMPLRT_DIV, CFG_SMPLRT};
		expw[4] = {MPU_ADDR, RA_CONFIG, CFG_LPF};
		expw[5] = {MPU_ADDR, RA_GYRO_CONFIG, CFG_GYRO};
		expw[6] = {MPU_ADDR, RA_ACCEL_CONFIG, CFG_ACCEL};
		expw[7] = {MPU_ADDR, RA_INT_ENABLE, CFG_INT_EN};
		wait_for_state(IDLE);
		compare("write log size", 32'(i_sensor_model.wr_log.size()), 32'd8);
		for (int i = 0; i < 8; i++) begin
			if (i < i_sensor_model.wr_log.size())
				compare($sformatf("write log entry %0d", i),
					32'(i_sensor_model.wr_log[i]), 32'(expw[i]));
		end
	endtask

	task automatic sample_readout(input int n);
		int         marks_before;
		int         log_before;
		int         len;
		logic       mag;
		logic [7:0] exp_byte;
		marks_before = marks;
		log_before   = i_sensor_model.wr_log.size();
		mag          = (n % int'(MAG_EVERY) == 0);
		len          = mag ? 20 : 14;
		do
			@(negedge CLK);
		while (!dat_rdy);
		compare("time_mark", 32'(marks - marks_before), 32'd1);
		compare("fifo_count", 32'(fifo_count), 32'(len));
		for (int k = 0; k < len; k++) begin
			if (k < 14)
				exp_byte = i_sensor_model.mpu_regs[RA_ACCEL_XOUT_H + 8'(k)];
			else
				exp_byte = i_sensor_model.ak_regs[AK_HXL[3:0] + 4'(k - 14)];
			compare("fifo_data", 32'(fifo_data), 32'(exp_byte));
			fifo_rd = 1'b1; // pop on the next rising edge
			@(negedge CLK);
		end
		fifo_rd = 1'b0;
		compare("fifo_count", 32'(fifo_count), 32'd0);
		compare("write log growth", 32'(i_sensor_model.wr_log.size() - log_before),
			mag ? 32'd1 : 32'd0);
		if (mag && i_sensor_model.wr_log.size() > log_before)
			compare("ak cntl write", 32'(i_sensor_model.wr_log[log_before]),
				32'({AK_ADDR, AK_CNTL, AK_SINGLE}));
	endtask

	task automatic bad_id_error();
		int log_before;
		log_before = i_sensor_model.wr_log.size();
		mpu_id = 8'h00;
		apply_reset();
		wait_for_state(ERR);
		repeat (1000) @(negedge CLK); // window for stray writes
		compare("state", 32'(state), 32'(ERR));
		compare("writes after bad id", 32'(i_sensor_model.wr_log.size() - log_before), 32'd0);
	endtask

	initial begin
		RSTn    = 1'b0;
		en      = 1'b1;
		fifo_rd = 1'b0;
		mpu_id  = MPU_ID;
		ak_id   = AK_ID;
		apply_reset();
		verify_reset_values();
		startup_sequence();
		for (int n = 1; n <= SAMPLES; n++)
			sample_readout(n);
		bad_id_error();
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- test/sensor_model.sv
// i2c slave model of the mpu9150 and the ak8975 behind its bypass, logging every register write
`timescale 1ns/10ps
module sensor_model
	import mpu_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTn,
	input  logic       scl,
	input  logic       sda,
	output logic       sda_low,
	input  logic [7:0] mpu_id,
	input  logic [7:0] ak_id
);

	logic [7:0]  mpu_regs [256];
	logic [7:0]  ak_regs [16];
	logic [22:0] wr_log [$]; // device, register, value
	logic        scl_q;
	logic        sda_q;
	logic        active;     // addressed since the last start
	logic        in_ack;
	logic        sending;
	logic        is_ak;
	logic        rd;
	logic        master_ack;
	logic [3:0]  bitc;
	logic [3:0]  byte_no;
	logic [7:0]  ptr;
	logic [7:0]  shreg;
	logic [7:0]  tx;
	logic [31:0] lfsr;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic logic [7:0] reg_read(input logic ak, input logic [7:0] a);
		if (ak)
			return (a == AK_WIA) ? ak_id : ak_regs[a[3:0]];
		return (a == RA_WHO_AM_I) ? mpu_id : mpu_regs[a];
	endfunction

	always @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			lfsr = 32'h3b63_06c3;
			for (int i = 0; i < 256; i++) begin
				for (int b = 0; b < 8; b++) begin
					lfsr  = lfsr_step(lfsr);
					shreg = {shreg[6:0], lfsr[0]};
				end
				mpu_regs[8'(i)] = shreg;
			end
			for (int i = 0; i < 16; i++) begin
				for (int b = 0; b < 8; b++) begin
					lfsr  = lfsr_step(lfsr);
					shreg = {shreg[6:0], lfsr[0]};
				end
				ak_regs[4'(i)] = shreg;
			end
			mpu_regs[RA_PWR_MGMT_1] = 8'h40; // device comes up asleep
			scl_q   = 1'b1;
			sda_q   = 1'b1;
			active  = 1'b0;
			in_ack  = 1'b0;
			sending = 1'b0;
			bitc    = 4'd0;
			byte_no = 4'd0;
			sda_low <= 1'b0;
		end else begin
			if (scl && scl_q && sda_q && !sda) begin // start or repeated start
				active  = 1'b1;
				in_ack  = 1'b0;
				sending = 1'b0;
				bitc    = 4'd0;
				byte_no = 4'd0;
				sda_low <= 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin // stop
				active  = 1'b0;
				sending = 1'b0;
				sda_low <= 1'b0;
			end else if (active && scl && !scl_q) begin
				if (in_ack) begin
					master_ack = !sda;
				end else begin
					shreg = {shreg[6:0], sda};
					bitc  = bitc + 4'd1;
				end
			end else if (active && !scl && scl_q) begin
				if (in_ack) begin
					in_ack = 1'b0;
					bitc   = 4'd0;
					if ((sending && master_ack) || (rd && !sending)) begin
						tx      = reg_read(is_ak, ptr);
						ptr     = ptr + 8'd1; // auto increment on burst reads
						sending = 1'b1;
						sda_low <= !tx[7];
					end else begin
						if (sending)
							active = 1'b0; // master nack ends the read
						sending = 1'b0;
						sda_low <= 1'b0;
					end
				end else if (bitc == 4'd8) begin
					in_ack = 1'b1;
					if (sending) begin
						sda_low <= 1'b0;
					end else begin
						if (byte_no == 4'd0) begin
							rd    = shreg[0];
							is_ak = (shreg[7:1] == AK_ADDR);
							if (shreg[7:1] == MPU_ADDR || is_ak)
								sda_low <= 1'b1;
							else
								active = 1'b0;
						end else if (byte_no == 4'd1) begin
							ptr = shreg;
							sda_low <= 1'b1;
						end else begin
							if (is_ak)
								ak_regs[ptr[3:0]] = shreg;
							else
								mpu_regs[ptr] = shreg;
							wr_log.push_back({is_ak ? AK_ADDR : MPU_ADDR, ptr, shreg});
							ptr = ptr + 8'd1;
							sda_low <= 1'b1;
						end
						if (byte_no != 4'd15)
							byte_no = byte_no + 4'd1;
					end
				end else if (sending) begin
					tx = {tx[6:0], 1'b0};
					sda_low <= !tx[7];
				end
			end
			scl_q = scl;
			sda_q = sda;
		end
	end

endmodule

//--- verilog/mpu9150_driver.sv
// mpu9150 driver top joining sequencer, timebase, i2c master and receive FIFO
`timescale 1ns/10ps
module mpu9150_driver
	import mpu_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTn,
	input  logic       en,
	output logic       scl,
	output logic       sda_oe,
	input  logic       sda_in,
	output logic       dat_rdy,
	output logic       time_mark,
	output drv_state_t state,
	input  logic       fifo_rd,
	output logic [7:0] fifo_data,
	output logic [5:0] fifo_count
);

	logic        req_wr;
	logic        req_rd;
	logic [6:0]  dev_addr;
	logic [7:0]  reg_addr;
	logic [7:0]  wr_data;
	logic [4:0]  rd_len;
	logic        done;
	logic        nack;
	logic        rx_valid;
	logic [7:0]  rx_data;
	logic        delay_start;
	logic [15:0] delay_us;
	logic        delay_done;
	logic        sample_tick;

	mpu_sequencer i_mpu_sequencer (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.en          (en),
		.req_wr      (req_wr),
		.req_rd      (req_rd),
		.dev_addr    (dev_addr),
		.reg_addr    (reg_addr),
		.wr_data     (wr_data),
		.rd_len      (rd_len),
		.done        (done),
		.nack        (nack),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.delay_start (delay_start),
		.delay_us    (delay_us),
		.delay_done  (delay_done),
		.sample_tick (sample_tick),
		.dat_rdy     (dat_rdy),
		.time_mark   (time_mark),
		.state       (state)
	);

	sensor_timebase i_sensor_timebase (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.delay_start (delay_start),
		.delay_us    (delay_us),
		.delay_done  (delay_done),
		.sample_tick (sample_tick)
	);

	i2c_master i_i2c_master (
		.CLK      (CLK),
		.RSTn     (RSTn),
		.req_wr   (req_wr),
		.req_rd   (req_rd),
		.dev_addr (dev_addr),
		.reg_addr (reg_addr),
		.wr_data  (wr_data),
		.rd_len   (rd_len),
		.busy     (),
		.done     (done),
		.nack     (nack),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.scl      (scl),
		.sda_oe   (sda_oe),
		.sda_in   (sda_in)
	);

	rx_fifo i_rx_fifo (
		.CLK     (CLK),
		.RSTn    (RSTn),
		.clear   (sample_tick), // flushed at each sample tick
		.wr      (rx_valid),
		.wr_data (rx_data),
		.rd      (fifo_rd),
		.rd_data (fifo_data),
		.count   (fifo_count)
	);

endmodule

//--- verilog/rx_fifo.sv
// receive byte FIFO with clear on sample tick, byte count and read port
`timescale 1ns/10ps
module rx_fifo
	import mpu_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTn,
	input  logic       clear,
	input  logic       wr,
	input  logic [7:0] wr_data,
	input  logic       rd,
	output logic [7:0] rd_data,
	output logic [5:0] count
);

	logic [7:0] mem [FIFO_DEPTH];
	logic [4:0] wptr;
	logic [4:0] rptr;
	logic       flush;
	logic       do_wr;
	logic       do_rd;

	assign flush   = clear && (count != 6'd0); // only a non-empty fifo is flushed
	assign do_wr   = wr && (count != 6'(FIFO_DEPTH)) && !flush;
	assign do_rd   = rd && (count != 6'd0) && !flush;
	assign rd_data = mem[rptr]; // head entry

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			wptr  <= 5'd0;
			rptr  <= 5'd0;
			count <= 6'd0;
		end else if (flush) begin
			wptr  <= 5'd0;
			rptr  <= 5'd0;
			count <= 6'd0;
		end else begin
			if (do_wr)
				wptr <= wptr + 5'd1;
			if (do_rd)
				rptr <= rptr + 5'd1;
			count <= count + {5'd0, do_wr} - {5'd0, do_rd};
		end
	end

	always_ff @(posedge CLK) begin
		if (do_wr)
			mem[wptr] <= wr_data;
	end

endmodule

//--- verilog/mpu_sequencer.sv
// mpu9150 sequencer for id check, wake-up, init and periodic sampling
`timescale 1ns/10ps
module mpu_sequencer
	import mpu_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTn,
	input  logic        en,
	output logic        req_wr,
	output logic        req_rd,
	output logic [6:0]  dev_addr,
	output logic [7:0]  reg_addr,
	output logic [7:0]  wr_data,
	output logic [4:0]  rd_len,
	input  logic        done,
	input  logic        nack,
	input  logic        rx_valid,
	input  logic [7:0]  rx_data,
	output logic        delay_start,
	output logic [15:0] delay_us,
	input  logic        delay_done,
	input  logic        sample_tick,
	output logic        dat_rdy,
	output logic        time_mark,
	output drv_state_t  state
);

	logic [3:0] step;
	logic       pending; // transfer issued, done not yet seen
	logic       waiting; // settle delay running
	logic [3:0] retries;
	logic [2:0] mag_cnt;
	logic       done_q;
	logic       nack_q;
	logic       dly_q;
	logic [7:0] rx_byte;
	pwr_mgmt_u  pwr;
	logic       xfer_end;
	logic       xfer_nack;
	logic       dly_end;
	logic       cmd_valid;
	logic       cmd_rd;
	logic [6:0] cmd_dev;
	logic [7:0] cmd_reg;
	logic [7:0] cmd_dat;
	logic [4:0] cmd_len;
	logic       issue;

	assign pwr.raw   = rx_byte;
	assign xfer_end  = done | done_q; // done_q holds a done seen while frozen
	assign xfer_nack = done ? nack : nack_q;
	assign dly_end   = delay_done | dly_q;
	assign issue     = en && cmd_valid && !pending && !waiting;

	// transfer for the current step
	always_comb begin
		cmd_valid = 1'b1;
		cmd_rd    = 1'b1;
		cmd_dev   = MPU_ADDR;
		cmd_reg   = RA_WHO_AM_I;
		cmd_dat   = 8'h00;
		cmd_len   = 5'd1;
		case (state)
		CHK: begin
			case (step)
			4'd0: cmd_reg = RA_WHO_AM_I;
			4'd1: cmd_reg = RA_PWR_MGMT_1;
			4'd2: begin
				cmd_rd  = 1'b0;
				cmd_reg = RA_PWR_MGMT_1; // clear sleep
			end
			4'd3: begin
				cmd_rd  = 1'b0;
				cmd_reg = RA_INT_PIN_CFG;
				cmd_dat = CFG_BYPASS;
			end
			4'd4: begin
				cmd_rd  = 1'b0;
				cmd_reg = RA_USER_CTRL;
			end
			default: begin
				cmd_dev = AK_ADDR;
				cmd_reg = AK_WIA;
			end
			endcase
		end
		INIT: begin
			cmd_rd = 1'b0;
			case (step)
			4'd0: begin
				cmd_reg = RA_SMPLRT_DIV;
				cmd_dat = CFG_SMPLRT;
			end
			4'd1: begin
				cmd_reg = RA_CONFIG;
				cmd_dat = CFG_LPF;
			end
			4'd2: begin
				cmd_reg = RA_GYRO_CONFIG;
				cmd_dat = CFG_GYRO;
			end
			4'd3: begin
				cmd_reg = RA_ACCEL_CONFIG;
				cmd_dat = CFG_ACCEL;
			end
			default: begin
				cmd_reg = RA_INT_ENABLE;
				cmd_dat = CFG_INT_EN;
			end
			endcase
		end
		SAMPLE: begin
			case (step)
			4'd0: begin
				cmd_reg = RA_ACCEL_XOUT_H;
				cmd_len = MPU_BURST;
			end
			4'd1: begin
				cmd_dev = AK_ADDR;
				cmd_reg = AK_HXL;
				cmd_len = MAG_BURST;
			end
			4'd2: begin
				cmd_rd  = 1'b0;
				cmd_dev = AK_ADDR;
				cmd_reg = AK_CNTL;
				cmd_dat = AK_SINGLE; // start next measurement
			end
			default: cmd_valid = 1'b0;
			endcase
		end
		default: cmd_valid = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			state       <= CHK;
			step        <= 4'd0;
			pending     <= 1'b0;
			waiting     <= 1'b0;
			retries     <= 4'd0;
			mag_cnt     <= 3'd0;
			done_q      <= 1'b0;
			nack_q      <= 1'b0;
			dly_q       <= 1'b0;
			req_wr      <= 1'b0;
			req_rd      <= 1'b0;
			delay_start <= 1'b0;
			dat_rdy     <= 1'b0;
			time_mark   <= 1'b0;
		end else begin
			req_wr      <= 1'b0;
			req_rd      <= 1'b0;
			delay_start <= 1'b0;
			dat_rdy     <= 1'b0;
			time_mark   <= 1'b0;
			if (done && !en) begin
				done_q <= 1'b1;
				nack_q <= nack;
			end
			if (delay_done && !en)
				dly_q <= 1'b1;
			if (en) begin
				if (issue) begin
					req_rd  <= cmd_rd;
					req_wr  <= ~cmd_rd;
					pending <= 1'b1;
				end
				if (dly_end) begin
					waiting <= 1'b0;
					dly_q   <= 1'b0;
				end
				if (xfer_end) begin
					pending <= 1'b0;
					done_q  <= 1'b0;
					case (state)
					CHK: begin
						case (step)
						4'd0: begin
							if (xfer_nack || rx_byte != MPU_ID) begin
								if (retries == ID_RETRIES - 4'd1)
									state <= ERR;
								else
									retries <= retries + 4'd1;
							end else begin
								retries <= 4'd0;
								step    <= 4'd1;
							end
						end
						4'd1: begin
							if (pwr.raw == 8'h00) begin
								step <= 4'd3; // already awake
							end else if (pwr.f.device_reset) begin
								waiting     <= 1'b1; // wait, then read again
								delay_start <= 1'b1;
							end else if (pwr.f.sleep) begin
								step <= 4'd2;
							end else begin
								step <= 4'd3;
							end
						end
						4'd2: begin
							step        <= 4'd3;
							waiting     <= 1'b1;
							delay_start <= 1'b1;
						end
						4'd3: step <= 4'd4;
						4'd4: step <= 4'd5;
						default: begin
							step <= 4'd0;
							if (xfer_nack || rx_byte != AK_ID)
								state <= ERR;
							else
								state <= INIT;
						end
						endcase
					end
					INIT: begin
						waiting     <= 1'b1;
						delay_start <= 1'b1;
						if (step == 4'd4) begin
							state <= IDLE;
							step  <= 4'd0;
						end else begin
							step <= step + 4'd1;
						end
					end
					SAMPLE: begin
						if (step == 4'd0) begin
							time_mark <= 1'b1;
							if (mag_cnt == MAG_EVERY - 3'd1) begin
								mag_cnt <= 3'd0;
								step    <= 4'd1;
							end else begin
								mag_cnt <= mag_cnt + 3'd1;
								step    <= 4'd3;
							end
						end else if (step == 4'd1) begin
							step <= 4'd2;
						end else begin
							step <= 4'd3;
						end
					end
					default: ;
					endcase
				end else if (state == IDLE && sample_tick && !waiting) begin
					state <= SAMPLE;
					step  <= 4'd0;
				end else if (state == SAMPLE && step == 4'd3) begin
					dat_rdy <= 1'b1; // all bytes of this sample are stored
					state   <= IDLE;
					step    <= 4'd0;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (issue) begin
			dev_addr <= cmd_dev;
			reg_addr <= cmd_reg;
			wr_data  <= cmd_dat;
			rd_len   <= cmd_len;
		end
		if (en && xfer_end)
			delay_us <= (state == CHK) ? WAKE_US : SETTLE_US;
		if (rx_valid)
			rx_byte <= rx_data;
	end

endmodule

//--- verilog/sensor_timebase.sv
// timebase with microsecond settle-delay countdown and periodic sample tick
`timescale 1ns/10ps
module sensor_timebase
	import mpu_pkg::*;
(
	input  logic        CLK,
	input  logic        RSTn,
	input  logic        delay_start,
	input  logic [15:0] delay_us,
	output logic        delay_done,
	output logic        sample_tick
);

	logic [7:0]  pre;
	logic [15:0] rem;
	logic        active;
	logic        us_tick;
	logic [23:0] scnt;

	assign us_tick     = active && (pre == 8'd0);
	assign delay_done  = us_tick && (rem == 16'd1);
	assign sample_tick = (scnt == SAMPLE_CYCLES - 24'd1);

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			pre    <= 8'd0;
			rem    <= 16'd0;
			active <= 1'b0;
		end else if (delay_start) begin
			pre    <= CLKS_PER_US - 8'd1; // prescaler restarts with the delay
			rem    <= delay_us;
			active <= 1'b1;
		end else if (us_tick) begin
			pre <= CLKS_PER_US - 8'd1;
			if (rem == 16'd1)
				active <= 1'b0;
			else
				rem <= rem - 16'd1;
		end else if (active) begin
			pre <= pre - 8'd1;
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn)
			scnt <= 24'd0;
		else if (sample_tick)
			scnt <= 24'd0;
		else
			scnt <= scnt + 24'd1; // free running from reset
	end

endmodule

//--- verilog/i2c_master.sv
// i2c master running one register write or one burst register read per request
`timescale 1ns/10ps
module i2c_master
	import mpu_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTn,
	input  logic       req_wr,
	input  logic       req_rd,
	input  logic [6:0] dev_addr,
	input  logic [7:0] reg_addr,
	input  logic [7:0] wr_data,
	input  logic [4:0] rd_len,
	output logic       busy,
	output logic       done,
	output logic       nack,
	output logic       rx_valid,
	output logic [7:0] rx_data,
	output logic       scl,
	output logic       sda_oe,
	input  logic       sda_in
);

	logic [7:0] qcnt;
	logic       qtick;
	logic [1:0] phase;    // quarter of the current bit slot
	logic       in_start; // slot is a (repeated) start
	logic       in_stop;
	logic [3:0] bitn;     // 0..7 data, 8 ack
	logic [1:0] bidx;     // addr w, reg, data or addr r, read data
	logic       rd_mode;
	logic [4:0] left;
	logic       nack_acc;
	logic       byte_slot;
	logic       rd_phase;
	logic       addr_byte;
	logic [6:0] a_dev;
	logic [7:0] a_reg;
	logic [7:0] a_dat;
	logic [7:0] tx_sh;
	logic [7:0] rx_sh;

	assign qtick     = busy && (qcnt == SCL_DIV - 8'd1);
	assign byte_slot = !in_start && !in_stop;
	assign rd_phase  = rd_mode && (bidx == 2'd3);
	assign addr_byte = (bidx == 2'd0) || (rd_mode && bidx == 2'd2);

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn)
			qcnt <= 8'd0;
		else if (!busy || qtick)
			qcnt <= 8'd0;
		else
			qcnt <= qcnt + 8'd1;
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			busy     <= 1'b0;
			done     <= 1'b0;
			nack     <= 1'b0;
			rx_valid <= 1'b0;
			scl      <= 1'b1;
			sda_oe   <= 1'b0;
			phase    <= 2'd0;
			in_start <= 1'b0;
			in_stop  <= 1'b0;
			bitn     <= 4'd0;
			bidx     <= 2'd0;
			rd_mode  <= 1'b0;
			left     <= 5'd0;
			nack_acc <= 1'b0;
		end else begin
			done     <= 1'b0;
			nack     <= 1'b0;
			rx_valid <= 1'b0;
			if (!busy) begin
				if (req_wr || req_rd) begin
					busy     <= 1'b1;
					in_start <= 1'b1;
					phase    <= 2'd0;
					bitn     <= 4'd0;
					bidx     <= 2'd0;
					rd_mode  <= req_rd;
					left     <= rd_len;
					nack_acc <= 1'b0;
				end
			end else if (qtick) begin
				phase <= phase + 2'd1;
				case (phase)
				2'd0: scl <= 1'b1;
				2'd1: begin
					if (in_start)
						sda_oe <= 1'b1; // start, sda falls with scl high
					else if (in_stop)
						sda_oe <= 1'b0; // stop, sda rises with scl high
					else if (bitn == 4'd8 && addr_byte && sda_in)
						nack_acc <= 1'b1;
				end
				2'd2: if (!in_stop) scl <= 1'b0;
				default: begin
					if (in_start) begin
						in_start <= 1'b0;
						bitn     <= 4'd0;
						sda_oe   <= ~tx_sh[7];
					end else if (in_stop) begin
						in_stop <= 1'b0;
						busy    <= 1'b0;
						done    <= 1'b1;
						nack    <= nack_acc;
					end else if (bitn != 4'd8) begin
						bitn <= bitn + 4'd1;
						if (bitn == 4'd7) begin
							if (rd_phase) begin
								sda_oe   <= (left != 5'd1); // ack all but the last byte
								rx_valid <= 1'b1;
							end else begin
								sda_oe <= 1'b0; // let the slave ack
							end
						end else begin
							sda_oe <= ~rd_phase & ~tx_sh[6];
						end
					end else begin
						bitn <= 4'd0;
						case (bidx)
						2'd0: begin
							bidx   <= 2'd1;
							sda_oe <= ~a_reg[7];
						end
						2'd1: begin
							bidx <= 2'd2;
							if (rd_mode) begin
								in_start <= 1'b1; // repeated start
								sda_oe   <= 1'b0;
							end else begin
								sda_oe <= ~a_dat[7];
							end
						end
						2'd2: begin
							if (rd_mode) begin
								bidx   <= 2'd3;
								sda_oe <= 1'b0;
							end else begin
								in_stop <= 1'b1;
								sda_oe  <= 1'b1;
							end
						end
						default: begin
							if (left == 5'd1) begin
								in_stop <= 1'b1;
								sda_oe  <= 1'b1;
							end else begin
								left   <= left - 5'd1;
								sda_oe <= 1'b0;
							end
						end
						endcase
					end
				end
				endcase
			end
		end
	end

	// shift registers and latched request
	always_ff @(posedge CLK) begin
		if (!busy && (req_wr || req_rd)) begin
			a_dev <= dev_addr;
			a_reg <= reg_addr;
			a_dat <= wr_data;
			tx_sh <= {dev_addr, 1'b0};
		end else if (qtick && byte_slot) begin
			if (phase == 2'd1 && rd_phase && bitn != 4'd8)
				rx_sh <= {rx_sh[6:0], sda_in};
			if (phase == 2'd3) begin
				if (bitn < 4'd7)
					tx_sh <= {tx_sh[6:0], 1'b0};
				else if (bitn == 4'd7)
					rx_data <= rx_sh;
				else if (bidx == 2'd0)
					tx_sh <= a_reg;
				else if (bidx == 2'd1)
					tx_sh <= rd_mode ? {a_dev, 1'b1} : a_dat;
			end
		end
	end

endmodule

//--- verilog/mpu_pkg.sv
// mpu9150 driver package with bus addresses, register map, config values and timing
package mpu_pkg;

	// 7-bit bus addresses
	localparam logic [6:0] MPU_ADDR = 7'h68;
	localparam logic [6:0] AK_ADDR  = 7'h0C; // magnetometer, reached through bypass

	// mpu register map
	localparam logic [7:0] RA_WHO_AM_I     = 8'h75;
	localparam logic [7:0] RA_PWR_MGMT_1   = 8'h6B;
	localparam logic [7:0] RA_INT_PIN_CFG  = 8'h37;
	localparam logic [7:0] RA_USER_CTRL    = 8'h6A;
	localparam logic [7:0] RA_SMPLRT_DIV   = 8'h19;
	localparam logic [7:0] RA_CONFIG       = 8'h1A;
	localparam logic [7:0] RA_GYRO_CONFIG  = 8'h1B;
	localparam logic [7:0] RA_ACCEL_CONFIG = 8'h1C;
	localparam logic [7:0] RA_INT_ENABLE   = 8'h38;
	localparam logic [7:0] RA_ACCEL_XOUT_H = 8'h3B; // start of accel/temp/gyro block

	// ak8975 register map
	localparam logic [7:0] AK_WIA  = 8'h00;
	localparam logic [7:0] AK_HXL  = 8'h03;
	localparam logic [7:0] AK_CNTL = 8'h0A;

	localparam logic [7:0] MPU_ID = 8'h68;
	localparam logic [7:0] AK_ID  = 8'h48;

	// configuration bytes
	localparam logic [7:0] CFG_SMPLRT = 8'h01; // 500 Hz output rate
	localparam logic [7:0] CFG_LPF    = 8'h03; // 42 Hz low pass
	localparam logic [7:0] CFG_GYRO   = 8'h18; // +-2000 dps
	localparam logic [7:0] CFG_ACCEL  = 8'h10; // +-8 g
	localparam logic [7:0] CFG_INT_EN = 8'h01; // data ready interrupt
	localparam logic [7:0] CFG_BYPASS = 8'h92; // i2c bypass enable
	localparam logic [7:0] AK_SINGLE  = 8'h01; // single measurement mode

	localparam logic [4:0] MPU_BURST  = 5'd14;
	localparam logic [4:0] MAG_BURST  = 5'd6;
	localparam logic [2:0] MAG_EVERY  = 3'd5;
	localparam logic [3:0] ID_RETRIES = 4'd5;

	// timing, scaled down for simulation
	localparam logic [7:0]  SCL_DIV       = 8'd4; // clk cycles per quarter scl period
	localparam logic [7:0]  CLKS_PER_US   = 8'd2;
	localparam logic [15:0] WAKE_US       = 16'd20;
	localparam logic [15:0] SETTLE_US     = 16'd5;
	localparam logic [23:0] SAMPLE_CYCLES = 24'd6000;

	localparam int FIFO_DEPTH = 32;

	typedef enum logic [2:0] {
		CHK    = 3'd0,
		INIT   = 3'd1,
		IDLE   = 3'd2,
		SAMPLE = 3'd4,
		ERR    = 3'd7
	} drv_state_t;

	// PWR_MGMT_1 seen as a whole byte or as its flag bits
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic       device_reset;
			logic       sleep;
			logic       cycle;
			logic [4:0] rest; // temp_dis and clock select
		} f;
	} pwr_mgmt_u;

endpackage
